//--- source/sm_pkg.sv
`default_nettype none

package sm_pkg;

  // ==================================================
  // identity and bus geometry
  // ==================================================
  localparam logic [31:0] FIRMWARE_ID      = 32'h5553_5250; // "USRP"
  localparam logic [31:0] FIRMWARE_VERSION = 32'h000A_0001; // major 10, minor 1
  localparam logic [31:0] DEFAULT_READ     = 32'hABAD_BABE; // unmapped reads

  localparam int DATA_W = 32; // bus and stream word
  localparam int ADDR_W = 14; // word address

  // word addresses
  localparam logic [ADDR_W-1:0] ADDR_ID          = 14'd0;
  localparam logic [ADDR_W-1:0] ADDR_VERSION     = 14'd1;
  localparam logic [ADDR_W-1:0] ADDR_SCRATCH     = 14'd2;
  localparam logic [ADDR_W-1:0] ADDR_PKT_CMD     = 14'd3; // also fires cmd_stb
  localparam logic [ADDR_W-1:0] ADDR_TIMER_START = 14'd4;
  localparam logic [ADDR_W-1:0] ADDR_TIMER_STOP  = 14'd5;
  localparam logic [ADDR_W-1:0] ADDR_TIMER0      = 14'd6;
  localparam logic [ADDR_W-1:0] ADDR_TIMER1      = 14'd7;
  localparam logic [ADDR_W-1:0] ADDR_TIMER2      = 14'd8;

  // ==================================================
  // packet framer
  // ==================================================
  localparam logic [7:0] MODE_SINGLE = 8'd2; // one packet, 2^(size-5) words
  localparam logic [7:0] MODE_RAW    = 8'd4; // 256-word packets

  localparam int SIZE_MIN_LOG = 5;
  localparam int SIZE_MAX_LOG = 12;
  localparam int RAW_WORDS    = 256; // data words per raw packet
  localparam int CREDIT_MAX   = 8;
  localparam int CREDIT_W     = 4;

  localparam logic [15:0] Q_START = 16'd32767; // q pattern seed

  // framer fsm encoding
  localparam logic [1:0] FSM_IDLE = 2'd0;
  localparam logic [1:0] FSM_HDR  = 2'd1;
  localparam logic [1:0] FSM_DATA = 2'd2;

  // timers
  localparam int N_TIMERS = 3;
  localparam int TIMER_W  = 32;

  // ==================================================
  // shared types
  // ==================================================
  typedef struct packed {
    logic              cs;
    logic              rnw;   // 1 = read
    logic [ADDR_W-1:0] addr;  // word address
    logic [DATA_W-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic [15:0] spare;    // bit 31 reads back as busy
    logic [7:0]  fft_size; // log2 of transform size
    logic [7:0]  mode;
  } pkt_cmd_t;

  // control word, written raw and consumed as a command
  typedef union packed {
    logic [DATA_W-1:0] raw;
    pkt_cmd_t          cmd;
  } ctl_word_u;

  typedef struct packed {
    logic              valid;
    logic              sof;  // header beat
    logic              eof;  // last beat of packet
    logic [DATA_W-1:0] data;
  } stream_t;

  typedef logic [N_TIMERS-1:0][TIMER_W-1:0] timer_arr_t;

endpackage

`default_nettype wire

//--- source/reg_bank.sv
`timescale 1ns/1ns
`default_nettype none

// processor-side register bank
module reg_bank (
  input  logic                      clk_ext,
  input  logic                      rst_ext,
  input  sm_pkg::bus_req_t          bus_req,
  output logic [sm_pkg::DATA_W-1:0] rdata,
  input  logic                      busy,     // framer still working
  input  sm_pkg::timer_arr_t        timers,
  output sm_pkg::pkt_cmd_t          cmd,
  output logic                      cmd_stb,
  output logic                      start_stb,
  output logic                      stop_stb
);

  logic                      wr;       // write cycle
  logic                      rd;       // read cycle
  logic                      cmd_ok;   // no command in flight
  logic                      wr_cmd;
  logic [sm_pkg::DATA_W-1:0] scratch;
  sm_pkg::ctl_word_u         ctl;      // last accepted command

  assign wr = bus_req.cs & ~bus_req.rnw;
  assign rd = bus_req.cs & bus_req.rnw;

  // strobe not yet seen as busy counts as busy too
  assign cmd_ok = ~busy & ~cmd_stb;
  assign wr_cmd = wr & (bus_req.addr == sm_pkg::ADDR_PKT_CMD) & cmd_ok;

  // ==================================================
  // write registers
  // ==================================================
  always_ff @(posedge clk_ext) begin
    if (rst_ext) begin
      scratch <= '0;
      ctl.raw <= '0;
    end else begin
      if (wr && (bus_req.addr == sm_pkg::ADDR_SCRATCH)) begin
        scratch <= bus_req.wdata;
      end
      if (wr_cmd) begin
        ctl.raw <= bus_req.wdata; // dropped while busy
      end
    end
  end

  // the framer sees the command through the union's cmd view
  assign cmd = ctl.cmd;

  // one-cycle write strobes
  always_ff @(posedge clk_ext) begin
    if (rst_ext) begin
      cmd_stb   <= 1'b0;
      start_stb <= 1'b0;
      stop_stb  <= 1'b0;
    end else begin
      cmd_stb   <= wr_cmd;
      start_stb <= wr & (bus_req.addr == sm_pkg::ADDR_TIMER_START);
      stop_stb  <= wr & (bus_req.addr == sm_pkg::ADDR_TIMER_STOP);
    end
  end

  // ==================================================
  // read decode
  // ==================================================
  always_comb begin
    rdata = '0; // idle bus reads zero
    if (rd) begin
      case (bus_req.addr)
        sm_pkg::ADDR_ID: begin
          rdata = sm_pkg::FIRMWARE_ID;
        end
        sm_pkg::ADDR_VERSION: begin
          rdata = sm_pkg::FIRMWARE_VERSION;
        end
        sm_pkg::ADDR_SCRATCH: begin
          rdata = scratch;
        end
        sm_pkg::ADDR_PKT_CMD: begin
          rdata                   = ctl.raw;
          rdata[sm_pkg::DATA_W-1] = busy; // status in spare msb
        end
        sm_pkg::ADDR_TIMER0: begin
          rdata = timers[0]; // cmd to first beat
        end
        sm_pkg::ADDR_TIMER1: begin
          rdata = timers[1]; // cmd to last beat
        end
        sm_pkg::ADDR_TIMER2: begin
          rdata = timers[2]; // sw start to sw stop
        end
        default: begin
          rdata = sm_pkg::DEFAULT_READ;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/pkt_framer.sv
`timescale 1ns/1ns
`default_nettype none

// packet framer with built-in i/q test pattern and credit flow control
module pkt_framer (
  input  logic             clk_ext,
  input  logic             rst_ext,
  input  sm_pkg::pkt_cmd_t cmd,
  input  logic             cmd_stb,
  input  logic             credit_return, // one credit back per pulse
  output sm_pkg::stream_t  stream,
  output logic             busy,
  output logic             first_beat,    // first header of a command sent
  output logic             last_beat      // final beat of a command sent
);

  logic [1:0]                  state;
  logic [sm_pkg::CREDIT_W-1:0] credits;
  logic                        mode_ok;
  logic                        accept;   // command taken this cycle
  logic                        issue;    // beat goes out this cycle
  logic                        pkt_end;  // last data word of packet
  logic                        cmd_end;  // last data word of command

  // clamped command fields
  logic [3:0] size_c;
  logic [7:0] total_c;
  logic [7:0] last_c;

  // latched command
  logic [7:0]  mode_q;
  logic [7:0]  total_q;  // packets in this command
  logic [7:0]  last_q;   // last word index in a packet
  logic [12:0] n_samp;   // 2^size pattern samples

  logic [7:0]  pkt_no;   // 1-based
  logic [7:0]  word_cnt; // data word in packet
  logic [15:0] samp;     // pattern position k

  // output beat
  logic                      beat_valid;
  logic                      beat_sof;
  logic                      beat_eof;
  logic [sm_pkg::DATA_W-1:0] beat_data;

  assign mode_ok = (cmd.mode == sm_pkg::MODE_SINGLE) || (cmd.mode == sm_pkg::MODE_RAW);
  assign accept  = cmd_stb && mode_ok;
  assign issue   = (state != sm_pkg::FSM_IDLE) && (credits != '0);
  assign pkt_end = (state == sm_pkg::FSM_DATA) && (word_cnt == last_q);
  assign cmd_end = pkt_end && (pkt_no == total_q);

  // ==================================================
  // command decode
  // ==================================================
  always_comb begin
    if (cmd.fft_size < 8'(sm_pkg::SIZE_MIN_LOG)) begin
      size_c = 4'(sm_pkg::SIZE_MIN_LOG);
    end else if (cmd.fft_size > 8'(sm_pkg::SIZE_MAX_LOG)) begin
      size_c = 4'(sm_pkg::SIZE_MAX_LOG);
    end else begin
      size_c = cmd.fft_size[3:0];
    end

    if (cmd.mode == sm_pkg::MODE_RAW) begin
      last_c = 8'(sm_pkg::RAW_WORDS - 1);
      // one packet per 256 samples, at least one
      if (size_c <= 4'($clog2(sm_pkg::RAW_WORDS))) begin
        total_c = 8'd1;
      end else begin
        total_c = 8'(1 << (size_c - 4'($clog2(sm_pkg::RAW_WORDS))));
      end
    end else begin
      last_c  = 8'((1 << (size_c - 4'(sm_pkg::SIZE_MIN_LOG))) - 1);
      total_c = 8'd1; // single mode
    end
  end

  // ==================================================
  // credits
  // ==================================================
  always_ff @(posedge clk_ext) begin
    if (rst_ext) begin
      credits <= sm_pkg::CREDIT_W'(sm_pkg::CREDIT_MAX);
    end else begin
      credits <= credits - sm_pkg::CREDIT_W'(issue) + sm_pkg::CREDIT_W'(credit_return);
    end
  end

  // ==================================================
  // packet fsm
  // ==================================================
  always_ff @(posedge clk_ext) begin
    if (rst_ext) begin
      state      <= sm_pkg::FSM_IDLE;
      busy       <= 1'b0;
      pkt_no     <= '0;
      word_cnt   <= '0;
      samp       <= '0;
      beat_valid <= 1'b0;
      beat_sof   <= 1'b0;
      beat_eof   <= 1'b0;
      first_beat <= 1'b0;
      last_beat  <= 1'b0;
    end else begin
      beat_valid <= issue;
      beat_sof   <= issue && (state == sm_pkg::FSM_HDR);
      beat_eof   <= issue && pkt_end;
      first_beat <= issue && (state == sm_pkg::FSM_HDR) && (pkt_no == 8'd1);
      last_beat  <= issue && cmd_end;

      if (accept) begin
        state  <= sm_pkg::FSM_HDR;
        busy   <= 1'b1;
        pkt_no <= 8'd1;
        samp   <= '0; // pattern restarts per command
      end else begin
        if (state == sm_pkg::FSM_IDLE) begin
          busy <= 1'b0; // one cycle after the last beat
        end
        // no credit, nothing moves
        if (issue) begin
          case (state)
            sm_pkg::FSM_HDR: begin
              state    <= sm_pkg::FSM_DATA;
              word_cnt <= '0;
            end
            sm_pkg::FSM_DATA: begin
              samp     <= samp + 16'd1;
              word_cnt <= word_cnt + 8'd1;
              if (cmd_end) begin
                state <= sm_pkg::FSM_IDLE;
              end else if (pkt_end) begin
                state  <= sm_pkg::FSM_HDR; // next raw packet
                pkt_no <= pkt_no + 8'd1;
              end
            end
            default: begin
              state <= sm_pkg::FSM_IDLE;
            end
          endcase
        end
      end
    end
  end

  // payload path
  always_ff @(posedge clk_ext) begin
    if (accept) begin
      mode_q  <= cmd.mode;
      total_q <= total_c;
      last_q  <= last_c;
      n_samp  <= 13'(1 << size_c);
    end
    if (issue) begin
      if (state == sm_pkg::FSM_HDR) begin
        beat_data <= {pkt_no, total_q, 8'h00, mode_q};
      end else if (samp < n_samp) begin
        beat_data <= {sm_pkg::Q_START + samp, samp}; // q high, i low
      end else begin
        beat_data <= '0; // raw padding past 2^size
      end
    end
  end

  assign stream = '{valid: beat_valid, sof: beat_sof, eof: beat_eof, data: beat_data};

endmodule

`default_nettype wire

//--- source/latency_timers.sv
`timescale 1ns/1ns
`default_nettype none

// start/stop cycle counters
module latency_timers (
  input  logic               clk_ext,
  input  logic               rst_ext,
  input  logic               cmd_stb,
  input  logic               first_beat,
  input  logic               last_beat,
  input  logic               start_stb,  // sw start write
  input  logic               stop_stb,   // sw stop write
  output sm_pkg::timer_arr_t timers
);

  logic [sm_pkg::N_TIMERS-1:0] start_vec;
  logic [sm_pkg::N_TIMERS-1:0] stop_vec;
  logic [sm_pkg::N_TIMERS-1:0] start_d;  // previous level
  logic [sm_pkg::N_TIMERS-1:0] stop_d;
  logic [sm_pkg::N_TIMERS-1:0] start_q;  // edge register
  logic [sm_pkg::N_TIMERS-1:0] stop_q;
  logic [sm_pkg::N_TIMERS-1:0] run;

  // timer 0 cmd..first beat, 1 cmd..last beat, 2 sw start..sw stop
  assign start_vec = {start_stb, cmd_stb, cmd_stb};
  assign stop_vec  = {stop_stb, last_beat, first_beat};

  // ==================================================
  // clear / run / hold
  // ==================================================
  always_ff @(posedge clk_ext) begin
    if (rst_ext) begin
      start_d <= '0;
      stop_d  <= '0;
      start_q <= '0;
      stop_q  <= '0;
      run     <= '0;
      timers  <= '0;
    end else begin
      start_d <= start_vec;
      stop_d  <= stop_vec;
      start_q <= start_vec & ~start_d; // rising edges only
      stop_q  <= stop_vec & ~stop_d;
      for (int i = 0; i < sm_pkg::N_TIMERS; i++) begin
        if (start_q[i]) begin
          timers[i] <= '0;
          run[i]    <= 1'b1;
        end else if (run[i]) begin
          timers[i] <= timers[i] + 1'b1; // stop edge still counts
        end
        if (stop_q[i] && !start_q[i]) begin
          run[i] <= 1'b0; // hold value
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- source/sm_top.sv
`timescale 1ns/1ns
`default_nettype none

// top level, register bank + framer + timers
module sm_top (
  input  logic                      clk_ext,
  input  logic                      rst_ext,
  input  sm_pkg::bus_req_t          bus_req,
  output logic [sm_pkg::DATA_W-1:0] rdata,
  output sm_pkg::stream_t           stream,
  input  logic                      credit_return
);

  sm_pkg::pkt_cmd_t   cmd;
  sm_pkg::timer_arr_t timers;
  logic               cmd_stb;
  logic               start_stb;
  logic               stop_stb;
  logic               busy;
  logic               first_beat;
  logic               last_beat;

  reg_bank u_reg_bank (
    .clk_ext   (clk_ext),
    .rst_ext   (rst_ext),
    .bus_req   (bus_req),
    .rdata     (rdata),
    .busy      (busy),
    .timers    (timers),
    .cmd       (cmd),
    .cmd_stb   (cmd_stb),
    .start_stb (start_stb),
    .stop_stb  (stop_stb)
  );

  pkt_framer u_pkt_framer (
    .clk_ext       (clk_ext),
    .rst_ext       (rst_ext),
    .cmd           (cmd),
    .cmd_stb       (cmd_stb),
    .credit_return (credit_return),
    .stream        (stream),
    .busy          (busy),
    .first_beat    (first_beat),
    .last_beat     (last_beat)
  );

  latency_timers u_latency_timers (
    .clk_ext    (clk_ext),
    .rst_ext    (rst_ext),
    .cmd_stb    (cmd_stb),
    .first_beat (first_beat),
    .last_beat  (last_beat),
    .start_stb  (start_stb),
    .stop_stb   (stop_stb),
    .timers     (timers)
  );

endmodule

`default_nettype wire

//--- include/tb_ref.svh
`ifndef TB_REF_SVH
`define TB_REF_SVH

// expected stream contents from mode and fft_size

function automatic int ref_size(input logic [7:0] fft_size);
  if (fft_size < sm_pkg::SIZE_MIN_LOG) return sm_pkg::SIZE_MIN_LOG;
  if (fft_size > sm_pkg::SIZE_MAX_LOG) return sm_pkg::SIZE_MAX_LOG;
  return int'(fft_size);
endfunction

function automatic bit ref_mode_ok(input logic [7:0] mode);
  return (mode == sm_pkg::MODE_SINGLE) || (mode == sm_pkg::MODE_RAW);
endfunction

function automatic int ref_total_pkts(input logic [7:0] mode, input logic [7:0] fft_size);
  int sz;
  sz = ref_size(fft_size);
  if (!ref_mode_ok(mode)) return 0; // unknown mode sends nothing
  if (mode == sm_pkg::MODE_SINGLE) return 1;
  if (sz <= $clog2(sm_pkg::RAW_WORDS)) return 1;
  return (1 << sz) / sm_pkg::RAW_WORDS;
endfunction

// data words per packet, header excluded
function automatic int ref_words_per_pkt(input logic [7:0] mode, input logic [7:0] fft_size);
  if (mode == sm_pkg::MODE_SINGLE) return 1 << (ref_size(fft_size) - sm_pkg::SIZE_MIN_LOG);
  if (mode == sm_pkg::MODE_RAW) return sm_pkg::RAW_WORDS;
  return 0;
endfunction

function automatic int ref_total_beats(input logic [7:0] mode, input logic [7:0] fft_size);
  return ref_total_pkts(mode, fft_size) * (ref_words_per_pkt(mode, fft_size) + 1);
endfunction

function automatic logic [sm_pkg::DATA_W-1:0] ref_header(input int pkt_no,
    input logic [7:0] mode, input logic [7:0] fft_size);
  return {8'(pkt_no), 8'(ref_total_pkts(mode, fft_size)), 8'h00, mode};
endfunction

// k counts data words across the whole command
function automatic logic [sm_pkg::DATA_W-1:0] ref_data(input logic [7:0] fft_size, input int k);
  if (k >= (1 << ref_size(fft_size))) return '0; // raw padding
  return {16'(sm_pkg::Q_START + k), 16'(k)};
endfunction

`endif

//--- testbench/tb_sm_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_sm_top;

  `include "tb_ref.svh"

  logic                      clk_ext;
  logic                      rst_ext;
  logic                      credit_return;
  sm_pkg::bus_req_t          bus_req;
  logic [sm_pkg::DATA_W-1:0] rdata;
  sm_pkg::stream_t           stream;

  sm_pkg::stream_t exp_q[$];          // beats still to come
  sm_pkg::stream_t exp_b;
  int              errors      = 0;
  int              checks      = 0;
  int              beats       = 0;   // valid beats seen
  int              outstanding = 0;   // beats not yet paid back
  int              owed        = 0;   // credits the receiver still has to return
  bit              hold_credits = 1'b0;
  integer          seed        = 32'hdb61;
  time             wr_edge;           // edge that took the last write

  sm_top uut (
    .clk_ext       (clk_ext),
    .rst_ext       (rst_ext),
    .bus_req       (bus_req),
    .rdata         (rdata),
    .stream        (stream),
    .credit_return (credit_return)
  );

  initial begin
    clk_ext = 1'b0;
    forever #10 clk_ext = ~clk_ext; // 20 ns period
  end

  // ==================================================
  // helpers
  // ==================================================
  task automatic compare_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[ERROR] %0t: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic require(input bit cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("%0t: %s", $time, what);
    end
  endtask

  task automatic write_reg(input logic [sm_pkg::ADDR_W-1:0] addr, input logic [31:0] data);
    @(posedge clk_ext);
    #2;
    bus_req = '{cs: 1'b1, rnw: 1'b0, addr: addr, wdata: data};
    @(posedge clk_ext);
    wr_edge = $time;
    #2;
    bus_req = '0;
  endtask

  task automatic read_reg(input logic [sm_pkg::ADDR_W-1:0] addr, output logic [31:0] data);
    @(posedge clk_ext);
    #2;
    bus_req = '{cs: 1'b1, rnw: 1'b1, addr: addr, wdata: '0};
    #8;
    data = rdata; // combinational read, settled mid cycle
    @(posedge clk_ext);
    #2;
    bus_req = '0;
  endtask

  // expected beats of one command, header first
  task automatic queue_expected(input logic [7:0] mode, input logic [7:0] size);
    int k;
    int p;
    int w;
    int wpp;
    k   = 0;
    wpp = ref_words_per_pkt(mode, size);
    for (p = 1; p <= ref_total_pkts(mode, size); p++) begin
      exp_q.push_back('{valid: 1'b1, sof: 1'b1, eof: 1'b0, data: ref_header(p, mode, size)});
      for (w = 0; w < wpp; w++) begin
        exp_q.push_back('{valid: 1'b1, sof: 1'b0, eof: (w == wpp - 1), data: ref_data(size, k)});
        k++; // pattern runs on across packets
      end
    end
  endtask

  task automatic run_command(input logic [7:0] mode, input logic [7:0] size);
    queue_expected(mode, size);
    write_reg(sm_pkg::ADDR_PKT_CMD, {16'h0000, size, mode});
  endtask

  // busy bit low and every expected beat in
  task automatic wait_idle();
    logic [31:0] status;
    status = '1;
    while (status[31] || (exp_q.size() > 0)) begin
      read_reg(sm_pkg::ADDR_PKT_CMD, status);
    end
    repeat (2) @(posedge clk_ext);
    #2;
  endtask

  // ==================================================
  // receiver and checker
  // ==================================================
  initial begin
    int gap;
    credit_return = 1'b0;
    forever begin
      @(posedge clk_ext);
      #2;
      credit_return = 1'b0;
      if ((owed > 0) && !hold_credits) begin
        gap = $unsigned($random(seed)) % 4; // 0..3 cycles
        if (gap > 0) begin
          repeat (gap) @(posedge clk_ext);
          #2;
        end
        credit_return = 1'b1; // one-cycle pulse
        owed--;
      end
    end
  end

  always @(posedge clk_ext) begin
    if (credit_return) begin
      outstanding--;
    end
    if (!rst_ext && (stream.valid === 1'b1)) begin
      beats++;
      outstanding++;
      owed++;
      require(exp_q.size() > 0, "beat arrived with no beat expected");
      if (exp_q.size() > 0) begin
        exp_b = exp_q.pop_front();
        compare_word(stream.data, exp_b.data, "stream data");
        compare_word({30'd0, stream.sof, stream.eof}, {30'd0, exp_b.sof, exp_b.eof},
                     "sof/eof flags");
      end
      require(outstanding <= sm_pkg::CREDIT_MAX, "more beats outstanding than credits");
    end
  end

  // timeout from the number of beats the run should carry
  initial begin
    int limit;
    limit = 20 * (ref_total_beats(sm_pkg::MODE_SINGLE, 8'd3)
                + ref_total_beats(sm_pkg::MODE_SINGLE, 8'd5)
                + ref_total_beats(sm_pkg::MODE_SINGLE, 8'd7)
                + ref_total_beats(sm_pkg::MODE_RAW, 8'd6)
                + 2 * ref_total_beats(sm_pkg::MODE_RAW, 8'd8)
                + ref_total_beats(sm_pkg::MODE_RAW, 8'd10) + 200);
    repeat (limit) @(posedge clk_ext);
    $display("timeout: the run did not finish within %0d cycles", limit);
    $display("checks: %0d, errors: %0d", checks, errors + 1);
    $display("Done: errors found");
    $finish;
  end

  // ==================================================
  // test sequence
  // ==================================================
  initial begin
    logic [31:0] v;
    logic [31:0] t0v;
    logic [31:0] t1v;
    logic [31:0] scr;
    time         t_start;
    int          b0;
    rst_ext = 1'b1;
    bus_req = '0;
    repeat (4) @(posedge clk_ext);
    #2;
    rst_ext = 1'b0;

    // register bank
    read_reg(sm_pkg::ADDR_SCRATCH, v);
    compare_word(v, 32'h0, "scratch after reset");
    read_reg(sm_pkg::ADDR_TIMER2, v);
    compare_word(v, 32'h0, "timer 2 after reset");
    read_reg(sm_pkg::ADDR_ID, v);
    compare_word(v, sm_pkg::FIRMWARE_ID, "id register");
    read_reg(sm_pkg::ADDR_VERSION, v);
    compare_word(v, sm_pkg::FIRMWARE_VERSION, "version register");
    read_reg(14'h1abc, v);
    compare_word(v, sm_pkg::DEFAULT_READ, "unmapped read");
    scr = $random(seed);
    write_reg(sm_pkg::ADDR_SCRATCH, scr);
    read_reg(sm_pkg::ADDR_SCRATCH, v);
    compare_word(v, scr, "scratch readback");

    // single mode, size 3 clamps up to 5
    run_command(sm_pkg::MODE_SINGLE, 8'd3);
    wait_idle();
    run_command(sm_pkg::MODE_SINGLE, 8'd5);
    wait_idle();
    run_command(sm_pkg::MODE_SINGLE, 8'd7);
    wait_idle();
    read_reg(sm_pkg::ADDR_TIMER0, t0v);
    read_reg(sm_pkg::ADDR_TIMER1, t1v);
    require((t0v > 0) && (t1v >= t0v), "timers 0 and 1 not set up by the last command");

    // raw mode, size 6 pads with zeros
    run_command(sm_pkg::MODE_RAW, 8'd6);
    wait_idle();
    run_command(sm_pkg::MODE_RAW, 8'd8);
    wait_idle();
    run_command(sm_pkg::MODE_RAW, 8'd10);
    repeat (30) @(posedge clk_ext);
    hold_credits = 1'b1; // starve the framer
    repeat (20) @(posedge clk_ext);
    #2;
    b0 = beats;
    repeat (60) @(posedge clk_ext);
    #2;
    require(beats == b0, "stream kept running with no credits returned");
    hold_credits = 1'b0;
    wait_idle();

    // command while busy is dropped
    run_command(sm_pkg::MODE_RAW, 8'd8);
    write_reg(sm_pkg::ADDR_PKT_CMD, {16'h0000, 8'd5, sm_pkg::MODE_SINGLE});
    read_reg(sm_pkg::ADDR_PKT_CMD, v);
    require(v[31], "busy bit low while a command runs");
    compare_word(32'(v[7:0]), 32'(sm_pkg::MODE_RAW), "command register after busy write");
    wait_idle();

    // unknown mode sends nothing
    b0 = beats;
    write_reg(sm_pkg::ADDR_PKT_CMD, {16'h0000, 8'd8, 8'd7});
    repeat (40) @(posedge clk_ext);
    #2;
    require(beats == b0, "unknown mode produced beats");
    read_reg(sm_pkg::ADDR_PKT_CMD, v);
    require(!v[31], "unknown mode raised busy");

    // software timer
    write_reg(sm_pkg::ADDR_TIMER_START, 32'h0);
    t_start = wr_edge;
    repeat (37) @(posedge clk_ext);
    write_reg(sm_pkg::ADDR_TIMER_STOP, 32'h0);
    repeat (4) @(posedge clk_ext);
    read_reg(sm_pkg::ADDR_TIMER2, v);
    compare_word(v, 32'((wr_edge - t_start) / 20), "timer 2 start to stop");

    require(exp_q.size() == 0, "expected beats never arrived");
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+include
source/sm_pkg.sv
source/reg_bank.sv
source/pkt_framer.sv
source/latency_timers.sv
source/sm_top.sv
testbench/tb_sm_top.sv

//--- Bender.yml
package:
  name: sm_top

sources:
  - source/sm_pkg.sv
  - source/reg_bank.sv
  - source/pkt_framer.sv
  - source/latency_timers.sv
  - source/sm_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_sm_top.sv
